/* design/sifhPkg.sv */
package sifhPkg;

    localparam int NP                = 10;  // Raw sample width
    localparam int PIXEL_NUM_PER_RAM = 3;   // Pixels per row, one lane each
    localparam int ROWS              = 2;
    localparam int SAMPLES_PER_PIXEL = 2;   // Samples averaged per pixel

    localparam int BIN_BITS = 3;
    localparam int BINS     = 1 << BIN_BITS;

    localparam int CNT_W                = 8;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;  // Saturation value 255

    localparam int ROW_W    = $clog2(ROWS);
    localparam int LANE_W   = $clog2(PIXEL_NUM_PER_RAM + 1);
    localparam int SAMPLE_W = $clog2(SAMPLES_PER_PIXEL);

    // One binned pixel
    typedef struct packed {
        logic [ROW_W-1:0]    row;
        logic [LANE_W-1:0]   pixel;
        logic [BIN_BITS-1:0] bin;
    } binEvent_t;

endpackage

/* design/memBusPkg.sv */
package memBusPkg;

    import sifhPkg::*;

    localparam int WORDS  = ROWS * BINS;      // One word per row and bin
    localparam int ADDR_W = $clog2(WORDS);

    // Lane 0 holds pixel 0 of the row
    typedef logic [PIXEL_NUM_PER_RAM-1:0][CNT_W-1:0] histWord_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;    // Row in the upper bit, bin below
        histWord_t         wdata;
    } memReq_t;

    typedef struct packed {
        logic [ROW_W-1:0]    row;
        logic [BIN_BITS-1:0] bin;
        histWord_t           counts;
    } readWord_t;

endpackage

/* design/histRam.sv */
`timescale 1ns/1ps

module histRam (
    input  logic                 clk,
    input  memBusPkg::memReq_t   req,
    output memBusPkg::histWord_t rdata
);
    import memBusPkg::*;

    histWord_t mem [WORDS];

    // Single port, read result lands one cycle later
    always_ff @(posedge clk) begin
        if (req.req) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

/* design/ramArbiter.sv */
`timescale 1ns/1ps

module ramArbiter (
    input  logic               clk,
    input  logic               rstN,
    input  memBusPkg::memReq_t updReq,
    input  memBusPkg::memReq_t rdReq,
    output memBusPkg::memReq_t memReq,
    output logic               updGrant,
    output logic               rdGrant,
    output logic               updRdValid,
    output logic               rdRdValid
);
    import memBusPkg::*;

    // Updater has fixed priority
    assign updGrant = updReq.req;
    assign rdGrant  = rdReq.req && !updReq.req;

    always_comb begin
        if (updGrant) begin
            memReq = updReq;
        end else if (rdGrant) begin
            memReq = rdReq;
        end else begin
            memReq = '0;          // Idle port
        end
    end

    // Owner of the word coming back next cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            updRdValid <= 1'b0;
            rdRdValid  <= 1'b0;
        end else begin
            updRdValid <= updGrant && !updReq.we;
            rdRdValid  <= rdGrant && !rdReq.we;
        end
    end

endmodule

/* design/pixelBinner.sv */
`timescale 1ns/1ps

module pixelBinner (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wrEn,
    input  logic [sifhPkg::NP-1:0] data,
    output logic                   evValid,
    output sifhPkg::binEvent_t     ev,
    output logic                   frameDone
);
    import sifhPkg::*;

    logic [SAMPLE_W-1:0] sampleIdx;
    logic [LANE_W-1:0]   pixelIdx;
    logic [ROW_W-1:0]    rowIdx;
    logic [NP-1:0]       firstSample;
    logic [NP:0]         sum;
    logic                lastSample;
    logic                lastPixel;
    logic                lastRow;

    assign sum        = firstSample + data;   // Mean is sum >> 1
    assign lastSample = (sampleIdx == SAMPLE_W'(SAMPLES_PER_PIXEL - 1));
    assign lastPixel  = (pixelIdx == LANE_W'(PIXEL_NUM_PER_RAM - 1));
    assign lastRow    = (rowIdx == ROW_W'(ROWS - 1));

    always_ff @(posedge clk) begin
        if (wrEn && !lastSample) begin
            firstSample <= data;
        end
    end

    // Top bits of the mean select the bin
    always_ff @(posedge clk) begin
        if (wrEn && lastSample) begin
            ev.row   <= rowIdx;
            ev.pixel <= pixelIdx;
            ev.bin   <= sum[NP -: BIN_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sampleIdx <= '0;
            pixelIdx  <= '0;
            rowIdx    <= '0;
            evValid   <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            evValid   <= wrEn && lastSample;
            frameDone <= evValid && (ev.row == ROW_W'(ROWS - 1))
                         && (ev.pixel == LANE_W'(PIXEL_NUM_PER_RAM - 1));
            if (wrEn) begin
                if (!lastSample) begin
                    sampleIdx <= sampleIdx + 1'b1;
                end else begin
                    sampleIdx <= '0;
                    if (lastPixel) begin
                        pixelIdx <= '0;
                        rowIdx   <= lastRow ? '0 : rowIdx + 1'b1;  // Wrap at frame end
                    end else begin
                        pixelIdx <= pixelIdx + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* design/histUpdater.sv */
`timescale 1ns/1ps

module histUpdater (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 evValid,
    input  sifhPkg::binEvent_t   ev,
    input  memBusPkg::histWord_t rdata,
    input  logic                 rdValid,
    input  logic                 grant,
    output memBusPkg::memReq_t   req
);
    import sifhPkg::*;
    import memBusPkg::*;

    binEvent_t       evReg;
    histWord_t       incWord;
    logic            pend;
    logic            doWrite;
    logic [CNT_W-1:0] laneCnt;

    assign doWrite = pend && rdValid;
    assign laneCnt = rdata[evReg.pixel];

    always_ff @(posedge clk) begin
        if (evValid) begin
            evReg <= ev;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pend <= 1'b0;
        end else if (evValid) begin
            pend <= 1'b1;
        end else if (doWrite && grant) begin
            pend <= 1'b0;                       // Write-back done
        end
    end

    // Increment only the event's lane
    always_comb begin
        incWord = rdata;
        if (laneCnt != CNT_MAX) begin
            incWord[evReg.pixel] = laneCnt + 1'b1;
        end
    end

    always_comb begin
        req = '0;
        if (evValid) begin
            req.req  = 1'b1;
            req.addr = {ev.row, ev.bin};        // Read phase
        end else if (doWrite) begin
            req.req   = 1'b1;
            req.we    = 1'b1;
            req.addr  = {evReg.row, evReg.bin};
            req.wdata = incWord;
        end
    end

endmodule

/* design/histReadout.sv */
`timescale 1ns/1ps

module histReadout (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 readStart,
    input  logic                 grant,
    input  memBusPkg::histWord_t rdata,
    input  logic                 rdValid,
    output memBusPkg::memReq_t   req,
    output logic                 outValid,
    output memBusPkg::readWord_t outWord,
    output logic                 readDone
);
    import sifhPkg::*;
    import memBusPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        CLEAR
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] addr;
    logic              lastAddr;

    assign lastAddr = (addr == ADDR_W'(WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            addr  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (readStart) begin
                        addr  <= '0;
                        state <= READ;
                    end
                end
                READ: begin
                    if (grant) begin
                        state <= CLEAR;         // Else retry next cycle
                    end
                end
                CLEAR: begin
                    if (grant) begin
                        addr  <= addr + 1'b1;
                        state <= lastAddr ? IDLE : READ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        req      = '0;
        req.req  = (state != IDLE);
        req.we   = (state == CLEAR);        // Clear with zero wdata
        req.addr = addr;
    end

    // Word is presented once, when its read returns
    assign outValid       = rdValid;
    assign readDone       = rdValid && lastAddr;
    assign outWord.row    = addr[ADDR_W-1 -: ROW_W];
    assign outWord.bin    = addr[BIN_BITS-1:0];
    assign outWord.counts = rdata;

endmodule

/* design/hisBuilder.sv */
`timescale 1ns/1ps

module hisBuilder (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wrEn,
    input  logic [sifhPkg::NP-1:0] data,
    input  logic                   readStart,
    output logic                   frameDone,
    output logic                   outValid,
    output memBusPkg::readWord_t   outWord,
    output logic                   readDone
);
    import sifhPkg::*;
    import memBusPkg::*;

    logic      evValid;
    binEvent_t ev;
    memReq_t   updReq;
    memReq_t   rdReq;
    memReq_t   memReq;
    histWord_t rdata;
    logic      updGrant;
    logic      rdGrant;
    logic      updRdValid;
    logic      rdRdValid;

    pixelBinner pixelBinner_i (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .data      (data),
        .evValid   (evValid),
        .ev        (ev),
        .frameDone (frameDone)
    );

    histUpdater histUpdater_i (
        .clk     (clk),
        .rstN    (rstN),
        .evValid (evValid),
        .ev      (ev),
        .rdata   (rdata),
        .rdValid (updRdValid),
        .grant   (updGrant),
        .req     (updReq)
    );

    histReadout histReadout_i (
        .clk       (clk),
        .rstN      (rstN),
        .readStart (readStart),
        .grant     (rdGrant),
        .rdata     (rdata),
        .rdValid   (rdRdValid),
        .req       (rdReq),
        .outValid  (outValid),
        .outWord   (outWord),
        .readDone  (readDone)
    );

    ramArbiter ramArbiter_i (
        .clk        (clk),
        .rstN       (rstN),
        .updReq     (updReq),
        .rdReq      (rdReq),
        .memReq     (memReq),
        .updGrant   (updGrant),
        .rdGrant    (rdGrant),
        .updRdValid (updRdValid),
        .rdRdValid  (rdRdValid)
    );

    histRam histRam_i (
        .clk   (clk),
        .req   (memReq),
        .rdata (rdata)
    );

endmodule

/* test/hisBuilderTb.sv */
`timescale 1ns/1ps

module hisBuilderTb;
    import sifhPkg::*;
    import memBusPkg::*;

    localparam int FRAME_SAMPLES = ROWS * PIXEL_NUM_PER_RAM * SAMPLES_PER_PIXEL;
    localparam int SAT_FRAMES    = 260;   // More frames than a counter can hold
    localparam int READ_LIMIT    = 200;   // Cycles allowed for a full readout
    localparam int FRAME_LIMIT   = 10;    // Cycles from last sample to frameDone

    logic          clk;
    logic          rstN;
    logic          wrEn;
    logic [NP-1:0] data;
    logic          readStart;
    logic          frameDone;
    logic          outValid;
    readWord_t     outWord;
    logic          readDone;

    logic [31:0]   lfsrState;
    logic [NP-1:0] frameSamples [FRAME_SAMPLES];
    int            model [ROWS][BINS][PIXEL_NUM_PER_RAM];  // Expected counters
    int            wordIdx;
    bit            checkCounts;
    string         testName;
    int            testErrors;
    int            totalErrors;
    int            testsPassed;
    int            testsFailed;

    hisBuilder hisBuilder_i (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .data      (data),
        .readStart (readStart),
        .frameDone (frameDone),
        .outValid  (outValid),
        .outWord   (outWord),
        .readDone  (readDone)
    );

    always #20 clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // Expected bin from the mean of two samples
    function automatic int refBin(input int first, input int second);
        int mean;
        mean = (first + second) / 2;
        return mean / (1 << (NP - BIN_BITS));
    endfunction

    task automatic randomSample(output logic [NP-1:0] value);
        value = '0;
        for (int i = 0; i < NP; i++) begin
            value     = {value[NP-2:0], lfsrState[0]};  // One step per bit
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic flagError();
        testErrors++;
        totalErrors++;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            $display("%-20s passed", testName);
            testsPassed++;
        end else begin
            $display("%-20s failed with %0d errors", testName, testErrors);
            testsFailed++;
        end
    endtask

    task automatic countEvent(input int row, input int pixel, input int bin);
        if (model[row][bin][pixel] < (1 << CNT_W) - 1) begin
            model[row][bin][pixel]++;                   // Saturates at the top
        end
    endtask

    // frameDone must stay low until the last pixel of the frame is binned
    task automatic checkFrameDoneLow();
        assert (!frameDone) else begin
            $display("%s: frameDone came before the last sample was binned", testName);
            flagError();
        end
    endtask

    task automatic driveSample(input logic [NP-1:0] value);
        @(posedge clk);
        wrEn <= 1'b1;
        data <= value;
        @(negedge clk);
        checkFrameDoneLow();
        @(posedge clk);
        wrEn <= 1'b0;
        @(negedge clk);
        checkFrameDoneLow();
    endtask

    task automatic fillRandom();
        for (int i = 0; i < FRAME_SAMPLES; i++) begin
            randomSample(frameSamples[i]);
        end
    endtask

    task automatic acquireFrame();
        int idx;
        int waited;
        bit seen;
        for (int r = 0; r < ROWS; r++) begin
            for (int p = 0; p < PIXEL_NUM_PER_RAM; p++) begin
                idx = (r * PIXEL_NUM_PER_RAM + p) * SAMPLES_PER_PIXEL;
                driveSample(frameSamples[idx]);
                driveSample(frameSamples[idx + 1]);
                countEvent(r, p, refBin(int'(frameSamples[idx]), int'(frameSamples[idx + 1])));
            end
        end
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < FRAME_LIMIT) begin
            @(negedge clk);
            seen = frameDone;
            waited++;
        end
        if (!seen) begin
            $display("%s: frameDone never came after the last sample", testName);
            flagError();
        end
    endtask

    task automatic readOut(input bit compareCounts);
        int waited;
        bit seen;
        checkCounts = compareCounts;
        wordIdx     = 0;
        @(posedge clk);
        readStart <= 1'b1;
        @(posedge clk);
        readStart <= 1'b0;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < READ_LIMIT) begin
            @(negedge clk);
            seen = readDone;
            waited++;
        end
        @(posedge clk);                                 // Let the last compare settle
        if (!seen) begin
            $display("%s: readDone did not arrive within %0d cycles", testName, READ_LIMIT);
            flagError();
        end
        assert (wordIdx == WORDS) else begin
            $display("ERROR %s: word count expected %0d actual %0d", testName, WORDS, wordIdx);
            flagError();
        end
    endtask

    // Checks each readout word in address order
    always @(negedge clk) begin
        histWord_t expWord;
        int        row;
        int        bin;
        if (outValid) begin
            if (wordIdx >= WORDS) begin
                $display("%s: readout gave more words than the memory holds", testName);
                flagError();
            end else begin
                row = wordIdx / BINS;
                bin = wordIdx % BINS;
                for (int p = 0; p < PIXEL_NUM_PER_RAM; p++) begin
                    expWord[p] = CNT_W'(model[row][bin][p]);
                end
                assert (outWord.row == ROW_W'(row) && outWord.bin == BIN_BITS'(bin)) else begin
                    $display("ERROR %s: position expected %0d/%0d actual %0d/%0d",
                             testName, row, bin, outWord.row, outWord.bin);
                    flagError();
                end
                if (checkCounts) begin
                    assert (outWord.counts == expWord) else begin
                        $display("ERROR %s: word %0d expected %h actual %h",
                                 testName, wordIdx, expWord, outWord.counts);
                        flagError();
                    end
                end
                for (int p = 0; p < PIXEL_NUM_PER_RAM; p++) begin
                    model[row][bin][p] = 0;             // Readout clears the word
                end
            end
            wordIdx++;
        end
    end

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        wrEn        = 1'b0;
        data        = '0;
        readStart   = 1'b0;
        lfsrState   = 32'd81786;
        checkCounts = 1'b0;
        wordIdx     = 0;
        totalErrors = 0;
        testsPassed = 0;
        testsFailed = 0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        startTest("resetClear");
        readOut(1'b0);                                  // Contents unknown before this
        readOut(1'b1);
        endTest();

        startTest("fixedPairs");
        frameSamples = '{10'd108, 10'd511, 10'd1007, 10'd1007, 10'd0, 10'd0,
                         10'd1023, 10'd0, 10'd200, 10'd300, 10'd700, 10'd900};
        acquireFrame();
        readOut(1'b1);
        endTest();

        startTest("randomAccumulate");
        fillRandom();
        acquireFrame();
        fillRandom();
        acquireFrame();
        readOut(1'b1);
        endTest();

        startTest("readoutClears");
        readOut(1'b1);                                  // Nothing new since last read
        fillRandom();
        acquireFrame();
        readOut(1'b1);
        endTest();

        startTest("saturation");
        for (int i = 0; i < FRAME_SAMPLES; i++) begin
            frameSamples[i] = '1;
        end
        repeat (SAT_FRAMES) acquireFrame();
        readOut(1'b1);
        endTest();

        $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed,
                 totalErrors);
        if (totalErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/sifhPkg.sv
design/memBusPkg.sv
design/histRam.sv
design/ramArbiter.sv
design/pixelBinner.sv
design/histUpdater.sv
design/histReadout.sv
design/hisBuilder.sv
test/hisBuilderTb.sv

/* run.sh */
#!/bin/sh
# Build the histogram builder testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f verilog.f --top-module hisBuilderTb -Mdir "$OBJ" -o hisBuilderSim
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

"./$OBJ/hisBuilderSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
